// File: rtl/miner_config.svh
/*
 * miner front end configuration
 * serial timing, core count, job buffer depth and frame field widths
 */
`ifndef MINER_CONFIG_SVH
`define MINER_CONFIG_SVH

// clocks per serial bit, kept short for simulation
`define UART_CLKS_PER_BIT 8

// hashing cores, 1 to 3
`define CN_CORES 2

// job buffer entries, 2 or 4
`define JOB_BUF_DEPTH 2

`define HASH_WORDS 12
`define XOUT_WORDS 8
`define WORD_BITS 128
`define TWEAK_BITS 64
`define JOB_BYTES 200
`define RESULT_BYTES 128

`endif

// File: rtl/miner_pkg.sv
/*
 * miner package
 * job and result frame types and the state encodings of the serial blocks
 */
`include "miner_config.svh"

package miner_pkg;

	// one job as received over the serial link, hash[0] is sent first
	typedef struct packed {
		logic [0:`HASH_WORDS-1][`WORD_BITS-1:0] hash;
		logic [`TWEAK_BITS-1:0]                 tweak;
	} job_t;

	// core output, xout[0] goes out first
	typedef struct packed {
		logic [0:`XOUT_WORDS-1][`WORD_BITS-1:0] xout;
	} result_t;

	// shared by the serial receiver and transmitter
	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_DATA,
		UART_STOP
	} uart_state_e;

	// result serialiser
	typedef enum logic [1:0] {
		SEND_IDLE,
		SEND_LOAD,
		SEND_WAIT_BUSY
	} send_state_e;

endpackage

// File: rtl/uart_receiver.sv
/*
 * uart receiver, 8N1
 * samples each bit at its middle and strobes the byte at the stop bit
 */
`timescale 1ns/10ps
`include "miner_config.svh"

module uart_receiver (
	input  logic       clk,
	input  logic       rst_i,
	input  logic       rxd_i,
	output logic [7:0] rx_byte_o,
	output logic       rx_en_o
);
	localparam int CLKS = `UART_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CLKS);

	miner_pkg::uart_state_e state_q;
	logic [CNT_W-1:0] clk_cnt_q;
	logic [2:0] bit_cnt_q;
	logic [7:0] shift_q;
	logic rxd_meta_q;
	logic rxd_q;

	// line idles high
	always_ff @(posedge clk) begin
		if (rst_i) begin
			rxd_meta_q <= 1'b1;
			rxd_q <= 1'b1;
		end else begin
			rxd_meta_q <= rxd_i;
			rxd_q <= rxd_meta_q;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= miner_pkg::UART_IDLE;
			clk_cnt_q <= '0;
			bit_cnt_q <= '0;
			rx_en_o <= 1'b0;
		end else begin
			rx_en_o <= 1'b0;
			case (state_q)
			miner_pkg::UART_IDLE: begin
				clk_cnt_q <= '0;
				if (!rxd_q)
					state_q <= miner_pkg::UART_START;
			end
			miner_pkg::UART_START: begin
				if (clk_cnt_q == CNT_W'(CLKS / 2 - 1)) begin
					clk_cnt_q <= '0;
					bit_cnt_q <= '0;
					// start bit gone by mid-bit, treat as a glitch
					state_q <= rxd_q ? miner_pkg::UART_IDLE : miner_pkg::UART_DATA;
				end else begin
					clk_cnt_q <= clk_cnt_q + 1'b1;
				end
			end
			miner_pkg::UART_DATA: begin
				if (clk_cnt_q == CNT_W'(CLKS - 1)) begin
					clk_cnt_q <= '0;
					bit_cnt_q <= bit_cnt_q + 1'b1;
					if (bit_cnt_q == 3'd7)
						state_q <= miner_pkg::UART_STOP;
				end else begin
					clk_cnt_q <= clk_cnt_q + 1'b1;
				end
			end
			default: begin
				if (clk_cnt_q == CNT_W'(CLKS - 1)) begin
					// a low stop bit drops the character
					rx_en_o <= rxd_q;
					state_q <= miner_pkg::UART_IDLE;
				end else begin
					clk_cnt_q <= clk_cnt_q + 1'b1;
				end
			end
			endcase
		end
	end

	// lsb first
	always_ff @(posedge clk) begin
		if (state_q == miner_pkg::UART_DATA && clk_cnt_q == CNT_W'(CLKS - 1))
			shift_q <= {rxd_q, shift_q[7:1]};
	end

	assign rx_byte_o = shift_q;

endmodule

// File: rtl/uart_sender.sv
/*
 * uart transmitter, 8N1
 * start bit, eight data bits lsb first, stop bit, busy while shifting
 */
`timescale 1ns/10ps
`include "miner_config.svh"

module uart_sender (
	input  logic       clk,
	input  logic       rst_i,
	input  logic       tx_en_i,
	input  logic [7:0] tx_byte_i,
	output logic       txd_o,
	output logic       busy_o
);
	localparam int CLKS = `UART_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CLKS);

	miner_pkg::uart_state_e state_q;
	logic [CNT_W-1:0] clk_cnt_q;
	logic [2:0] bit_cnt_q;
	logic [7:0] shift_q;
	logic bit_end;

	assign bit_end = (clk_cnt_q == CNT_W'(CLKS - 1));

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= miner_pkg::UART_IDLE;
			clk_cnt_q <= '0;
			bit_cnt_q <= '0;
		end else begin
			clk_cnt_q <= (state_q == miner_pkg::UART_IDLE || bit_end) ? '0 : clk_cnt_q + 1'b1;
			case (state_q)
			miner_pkg::UART_IDLE: begin
				bit_cnt_q <= '0;
				if (tx_en_i)
					state_q <= miner_pkg::UART_START;
			end
			miner_pkg::UART_START: begin
				if (bit_end)
					state_q <= miner_pkg::UART_DATA;
			end
			miner_pkg::UART_DATA: begin
				if (bit_end) begin
					bit_cnt_q <= bit_cnt_q + 1'b1;
					if (bit_cnt_q == 3'd7)
						state_q <= miner_pkg::UART_STOP;
				end
			end
			default: begin
				if (bit_end)
					state_q <= miner_pkg::UART_IDLE;
			end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == miner_pkg::UART_IDLE && tx_en_i)
			shift_q <= tx_byte_i;
		else if (state_q == miner_pkg::UART_DATA && bit_end)
			shift_q <= {1'b0, shift_q[7:1]};
	end

	assign txd_o = (state_q == miner_pkg::UART_START) ? 1'b0 :
	               (state_q == miner_pkg::UART_DATA) ? shift_q[0] : 1'b1;
	assign busy_o = (state_q != miner_pkg::UART_IDLE);

endmodule

// File: rtl/job_receive.sv
/*
 * job assembly
 * shifts serial bytes into a job frame, first byte lands in the top byte
 */
`timescale 1ns/10ps
`include "miner_config.svh"

module job_receive (
	input  logic             clk,
	input  logic             rst_i,
	input  logic             rx_en_i,
	input  logic [7:0]       rx_byte_i,
	output miner_pkg::job_t  job_o,
	output logic             job_ready_o
);
	localparam int JOB_BITS = `JOB_BYTES * 8;
	localparam int CNT_W = $clog2(`JOB_BYTES);

	logic [JOB_BITS-1:0] shift_q;
	logic [CNT_W-1:0] byte_cnt_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			byte_cnt_q <= '0;
			job_ready_o <= 1'b0;
		end else begin
			job_ready_o <= 1'b0;
			if (rx_en_i) begin
				if (byte_cnt_q == CNT_W'(`JOB_BYTES - 1)) begin
					byte_cnt_q <= '0;
					job_ready_o <= 1'b1;
				end else begin
					byte_cnt_q <= byte_cnt_q + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_en_i)
			shift_q <= {shift_q[JOB_BITS-9:0], rx_byte_i};
	end

	assign job_o = shift_q;

endmodule

// File: rtl/job_dispatch.sv
/*
 * job dispatch
 * buffers received jobs and starts them on the lowest free core,
 * one start per cycle, each core keeping its own copy of the job
 */
`timescale 1ns/10ps
`include "miner_config.svh"

module job_dispatch (
	input  logic                                clk,
	input  logic                                rst_i,
	input  miner_pkg::job_t                     job_i,
	input  logic                                job_ready_i,
	input  logic [`CN_CORES-1:0]                core_main_ready_i,
	output logic [`CN_CORES-1:0]                core_go_o,
	output miner_pkg::job_t [`CN_CORES-1:0]     core_job_o,
	output logic [`CN_CORES-1:0]                core_busy_o
);
	localparam int CORES = `CN_CORES;
	localparam int DEPTH = `JOB_BUF_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	miner_pkg::job_t buf_mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] pending_q;
	logic [CORES-1:0] free;
	logic [CORES-1:0] start_sel;
	logic accept;
	logic start;

	// a job arriving on a full buffer is lost
	assign accept = job_ready_i && (pending_q != CNT_W'(DEPTH));

	// lowest set bit of the free vector
	assign free = ~core_busy_o;
	assign start_sel = (pending_q != '0) ? (free & (~free + 1'b1)) : '0;
	assign start = |start_sel;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			pending_q <= '0;
		end else begin
			if (accept)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (start)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({accept, start})
			2'b10: pending_q <= pending_q + 1'b1;
			2'b01: pending_q <= pending_q - 1'b1;
			default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			buf_mem[wr_ptr_q] <= job_i;
	end

	// busy drops at main loop end, the core may already take the next job
	always_ff @(posedge clk) begin
		if (rst_i) begin
			core_go_o <= '0;
			core_busy_o <= '0;
		end else begin
			core_go_o <= start_sel;
			core_busy_o <= start_sel | (core_busy_o & ~core_main_ready_i);
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < CORES; i++) begin
			if (start_sel[i])
				core_job_o[i] <= buf_mem[rd_ptr_q];
		end
	end

endmodule

// File: rtl/result_collect.sv
/*
 * result collection
 * marks finished cores and hands one result at a time to the sender,
 * lowest finished core first
 */
`timescale 1ns/10ps
`include "miner_config.svh"

module result_collect (
	input  logic                                clk,
	input  logic                                rst_i,
	input  logic [`CN_CORES-1:0]                core_ready_i,
	input  miner_pkg::result_t [`CN_CORES-1:0]  core_result_i,
	input  logic                                send_ready_i,
	output miner_pkg::result_t                  result_o,
	output logic                                send_go_o
);
	localparam int CORES = `CN_CORES;

	logic [CORES-1:0] done_q;
	logic [CORES-1:0] pick_sel;
	logic sending_q;
	logic pick;

	assign pick_sel = sending_q ? '0 : (done_q & (~done_q + 1'b1));
	assign pick = |pick_sel;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			done_q <= '0;
			sending_q <= 1'b0;
			send_go_o <= 1'b0;
		end else begin
			// a fresh ready keeps the flag even when picked on the same cycle
			done_q <= (done_q & ~pick_sel) | core_ready_i;
			send_go_o <= pick;
			if (pick)
				sending_q <= 1'b1;
			else if (send_ready_i)
				sending_q <= 1'b0;
		end
	end

	// held stable for the whole frame
	always_ff @(posedge clk) begin
		for (int i = 0; i < CORES; i++) begin
			if (pick_sel[i])
				result_o <= core_result_i[i];
		end
	end

endmodule

// File: rtl/result_send.sv
/*
 * result serialiser
 * feeds the latched result to the uart byte by byte, top byte first
 */
`timescale 1ns/10ps
`include "miner_config.svh"

module result_send (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                send_go_i,
	input  miner_pkg::result_t  result_i,
	input  logic                tx_busy_i,
	output logic                tx_en_o,
	output logic [7:0]          tx_byte_o,
	output logic                send_ready_o
);
	localparam int BYTES = `RESULT_BYTES;
	localparam int IDX_W = $clog2(BYTES + 1);

	miner_pkg::send_state_e state_q;
	logic [IDX_W-1:0] byte_idx_q;
	logic [BYTES*8-1:0] res_vec;

	assign res_vec = result_i;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= miner_pkg::SEND_IDLE;
			byte_idx_q <= '0;
			tx_en_o <= 1'b0;
			send_ready_o <= 1'b0;
		end else begin
			tx_en_o <= 1'b0;
			send_ready_o <= 1'b0;
			case (state_q)
			miner_pkg::SEND_IDLE: begin
				byte_idx_q <= '0;
				if (send_go_i)
					state_q <= miner_pkg::SEND_LOAD;
			end
			miner_pkg::SEND_LOAD: begin
				// index reaches BYTES once the last byte has left the line
				if (!tx_busy_i) begin
					if (byte_idx_q == IDX_W'(BYTES)) begin
						send_ready_o <= 1'b1;
						state_q <= miner_pkg::SEND_IDLE;
					end else begin
						tx_en_o <= 1'b1;
						state_q <= miner_pkg::SEND_WAIT_BUSY;
					end
				end
			end
			default: begin
				// busy rises one cycle after the enable
				if (tx_busy_i) begin
					byte_idx_q <= byte_idx_q + 1'b1;
					state_q <= miner_pkg::SEND_LOAD;
				end
			end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == miner_pkg::SEND_LOAD && !tx_busy_i && byte_idx_q != IDX_W'(BYTES))
			tx_byte_o <= res_vec[(BYTES - 1 - int'(byte_idx_q)) * 8 +: 8];
	end

endmodule

// File: rtl/miner.sv
/*
 * miner front end
 * serial job intake, dispatch to external hashing cores and
 * serial return of their results
 */
`timescale 1ns/10ps
`include "miner_config.svh"

module miner (
	input  logic                                clk,
	input  logic                                rst_i,
	input  logic                                rxd_i,
	input  logic [`CN_CORES-1:0]                core_main_ready_i,
	input  logic [`CN_CORES-1:0]                core_ready_i,
	input  miner_pkg::result_t [`CN_CORES-1:0]  core_result_i,
	output logic                                txd_o,
	output logic [`CN_CORES-1:0]                core_go_o,
	output miner_pkg::job_t [`CN_CORES-1:0]     core_job_o,
	output logic [`CN_CORES-1:0]                core_busy_o
);
	logic [7:0] rx_byte;
	logic rx_en;
	miner_pkg::job_t job;
	logic job_ready;
	miner_pkg::result_t result;
	logic send_go;
	logic send_ready;
	logic [7:0] tx_byte;
	logic tx_en;
	logic tx_busy;

	uart_receiver i_uart_receiver (
		.clk       (clk),
		.rst_i     (rst_i),
		.rxd_i     (rxd_i),
		.rx_byte_o (rx_byte),
		.rx_en_o   (rx_en)
	);

	job_receive i_job_receive (
		.clk         (clk),
		.rst_i       (rst_i),
		.rx_en_i     (rx_en),
		.rx_byte_i   (rx_byte),
		.job_o       (job),
		.job_ready_o (job_ready)
	);

	job_dispatch i_job_dispatch (
		.clk               (clk),
		.rst_i             (rst_i),
		.job_i             (job),
		.job_ready_i       (job_ready),
		.core_main_ready_i (core_main_ready_i),
		.core_go_o         (core_go_o),
		.core_job_o        (core_job_o),
		.core_busy_o       (core_busy_o)
	);

	result_collect i_result_collect (
		.clk           (clk),
		.rst_i         (rst_i),
		.core_ready_i  (core_ready_i),
		.core_result_i (core_result_i),
		.send_ready_i  (send_ready),
		.result_o      (result),
		.send_go_o     (send_go)
	);

	result_send i_result_send (
		.clk          (clk),
		.rst_i        (rst_i),
		.send_go_i    (send_go),
		.result_i     (result),
		.tx_busy_i    (tx_busy),
		.tx_en_o      (tx_en),
		.tx_byte_o    (tx_byte),
		.send_ready_o (send_ready)
	);

	uart_sender i_uart_sender (
		.clk       (clk),
		.rst_i     (rst_i),
		.tx_en_i   (tx_en),
		.tx_byte_i (tx_byte),
		.txd_o     (txd_o),
		.busy_o    (tx_busy)
	);

endmodule

// File: testbench/tb_miner.sv
/*
 * miner front end testbench
 * serial host, modeled hashing cores and a result frame capture,
 * driven from a scenario table
 */
`timescale 1ns/10ps
`include "miner_config.svh"

module tb_miner;

	localparam int CLKS = `UART_CLKS_PER_BIT;
	localparam int JOB_CYCLES = `JOB_BYTES * 10 * CLKS;
	localparam int RES_CYCLES = `RESULT_BYTES * 10 * CLKS;
	localparam int ROWS = 5;
	localparam int MAXJ = 5;

	logic clk = 1'b0;
	logic rst_i;
	logic rxd_i;
	logic [`CN_CORES-1:0] core_main_ready_i;
	logic [`CN_CORES-1:0] core_ready_i;
	miner_pkg::result_t [`CN_CORES-1:0] core_result_i;
	logic txd_o;
	logic [`CN_CORES-1:0] core_go_o;
	miner_pkg::job_t [`CN_CORES-1:0] core_job_o;
	logic [`CN_CORES-1:0] core_busy_o;

	// scenario table with per-job columns indexed by job number
	// lat_tab holds the core latency in cycles with core 0 first
	string name_tab [ROWS] = '{"single", "pair", "tie", "buffered", "overflow"};
	int jobs_tab [ROWS] = '{1, 2, 2, 3, 5};
	int acc_tab [ROWS] = '{1, 2, 2, 3, 4};
	int gap_tab [ROWS] = '{0, 40, 0, 0, 0};
	int lat_tab [ROWS][2] = '{'{20, 20}, '{20000, 100}, '{16100, 100},
		'{40000, 20000}, '{70000, 70000}};
	int core_tab [ROWS][MAXJ] = '{'{0, 0, 0, 0, 0}, '{0, 1, 0, 0, 0},
		'{0, 1, 0, 0, 0}, '{0, 1, 1, 0, 0}, '{0, 1, 0, 1, 0}};
	// job number of each result frame in arrival order
	int order_tab [ROWS][MAXJ] = '{'{0, 0, 0, 0, 0}, '{1, 0, 0, 0, 0},
		'{0, 1, 0, 0, 0}, '{1, 0, 2, 0, 0}, '{0, 1, 2, 3, 0}};
	// busy vector seen on each start
	logic [`CN_CORES-1:0] busy_tab [ROWS][MAXJ] = '{
		'{2'b01, 2'b00, 2'b00, 2'b00, 2'b00}, '{2'b01, 2'b11, 2'b00, 2'b00, 2'b00},
		'{2'b01, 2'b11, 2'b00, 2'b00, 2'b00}, '{2'b01, 2'b11, 2'b11, 2'b00, 2'b00},
		'{2'b01, 2'b11, 2'b11, 2'b11, 2'b00}};

	int row;
	int cycles;
	int limit;
	logic [31:0] lfsr_q = 32'h7de5;
	int go_cnt [`CN_CORES];
	miner_pkg::job_t go_job [`CN_CORES];
	int go_log [$];
	int go_cyc [$];
	miner_pkg::job_t job_log [$];
	logic [`CN_CORES-1:0] busy_log [$];
	miner_pkg::result_t frames [$];

	miner i_miner (
		.clk               (clk),
		.rst_i             (rst_i),
		.rxd_i             (rxd_i),
		.core_main_ready_i (core_main_ready_i),
		.core_ready_i      (core_ready_i),
		.core_result_i     (core_result_i),
		.txd_o             (txd_o),
		.core_go_o         (core_go_o),
		.core_job_o        (core_job_o),
		.core_busy_o       (core_busy_o)
	);

	always #10 clk = ~clk;

	task automatic abort_run();
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic compare_job(string test, miner_pkg::job_t exp, miner_pkg::job_t act);
		if (act !== exp) begin
			$display("ERROR %s: expected job %h, actual %h", test, exp, act);
			abort_run();
		end
	endtask

	task automatic compare_result(string test, miner_pkg::result_t exp,
			miner_pkg::result_t act);
		if (act !== exp) begin
			$display("ERROR %s: expected result %h, actual %h", test, exp, act);
			abort_run();
		end
	endtask

	task automatic compare_busy(string test, logic [`CN_CORES-1:0] exp,
			logic [`CN_CORES-1:0] act);
		if (act !== exp) begin
			$display("ERROR %s: expected %b, actual %b", test, exp, act);
			abort_run();
		end
	endtask

	task automatic compare_core(string test, int exp, int act);
		if (act != exp) begin
			$display("ERROR %s: expected core %0d, actual core %0d", test, exp, act);
			abort_run();
		end
	endtask

	task automatic compare_count(string test, int exp, int act);
		if (act != exp) begin
			$display("ERROR %s: expected %0d, actual %0d", test, exp, act);
			abort_run();
		end
	endtask

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic make_job(output miner_pkg::job_t j);
		logic [`JOB_BYTES*8-1:0] v;
		for (int i = 0; i < `JOB_BYTES * 8; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v[i] = lfsr_q[0];
		end
		j = v;
	endtask

	// what a modeled core returns for a job
	function automatic miner_pkg::result_t model_result(miner_pkg::job_t j, int core);
		miner_pkg::result_t r;
		for (int w = 0; w < `XOUT_WORDS; w++)
			r.xout[w] = j.hash[w] ^ {2{j.tweak}};
		r.xout[`XOUT_WORDS-1][7:0] = 8'(core);
		return r;
	endfunction

	// entered and left 1 ns after a rising edge
	task automatic send_byte(logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int k = 0; k < 10; k++) begin
			rxd_i = bits[k];
			repeat (CLKS) @(posedge clk);
			#1;
		end
	endtask

	task automatic send_job(miner_pkg::job_t j);
		logic [`JOB_BYTES*8-1:0] v;
		v = j;
		for (int b = 0; b < `JOB_BYTES; b++)
			send_byte(v[(`JOB_BYTES - 1 - b) * 8 +: 8]);
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (limit != 0 && cycles > limit) begin
			$display("run did not finish within %0d cycles", limit);
			abort_run();
		end
	end

	// log every core start with its job and the busy vector
	always @(negedge clk) begin
		for (int c = 0; c < `CN_CORES; c++) begin
			if (core_go_o[c]) begin
				go_job[c] = core_job_o[c];
				go_log.push_back(c);
				go_cyc.push_back(cycles);
				job_log.push_back(core_job_o[c]);
				busy_log.push_back(core_busy_o);
				go_cnt[c] = go_cnt[c] + 1;
			end
		end
	end

	for (genvar c = 0; c < `CN_CORES; c++) begin : g_core
		logic main_ready;
		logic ready;
		miner_pkg::result_t result;

		assign core_main_ready_i[c] = main_ready;
		assign core_ready_i[c] = ready;
		assign core_result_i[c] = result;

		// a start that lands during the ready tail is picked up afterwards
		initial begin : model
			int taken;
			miner_pkg::job_t job;
			taken = 0;
			main_ready = 1'b0;
			ready = 1'b0;
			result = '0;
			forever begin
				wait (go_cnt[c] != taken);
				taken++;
				job = go_job[c];
				repeat (lat_tab[row][c]) @(posedge clk);
				#1 main_ready = 1'b1;
				@(posedge clk);
				#1 main_ready = 1'b0;
				repeat (3) @(posedge clk);
				#1;
				result = model_result(job, c);
				ready = 1'b1;
				@(posedge clk);
				#1 ready = 1'b0;
			end
		end
	end

	// serial capture samples each bit at its middle on the falling clock
	initial begin : capture
		logic [7:0] b;
		logic [`RESULT_BYTES*8-1:0] frame;
		int n;
		n = 0;
		frame = '0;
		wait (rst_i === 1'b0);
		forever begin
			@(negedge clk);
			if (txd_o === 1'b0) begin
				repeat (CLKS / 2) @(negedge clk);
				for (int k = 0; k < 8; k++) begin
					repeat (CLKS) @(negedge clk);
					b[k] = txd_o;
				end
				repeat (CLKS) @(negedge clk);
				if (txd_o !== 1'b1) begin
					$display("stop bit low on the result line");
					abort_run();
				end
				frame = {frame[`RESULT_BYTES*8-9:0], b};
				n++;
				if (n == `RESULT_BYTES) begin
					frames.push_back(frame);
					n = 0;
				end
			end
		end
	end

	initial begin : main
		miner_pkg::job_t sent [MAXJ];
		int go_base;
		int frame_base;
		int end_cyc;
		int j;
		string test;
		row = 0;
		cycles = 0;
		end_cyc = 0;
		rst_i = 1'b1;
		rxd_i = 1'b1;
		limit = 16;
		for (int r = 0; r < ROWS; r++)
			limit += jobs_tab[r] * (JOB_CYCLES + gap_tab[r]) +
				acc_tab[r] * (RES_CYCLES + lat_tab[r][0] + lat_tab[r][1]);
		limit = limit * 2;

		repeat (16) @(posedge clk);
		#1 rst_i = 1'b0;
		@(negedge clk);
		if (txd_o !== 1'b1) begin
			$display("ERROR reset txd: expected 1, actual %b", txd_o);
			abort_run();
		end
		compare_busy("reset go", '0, core_go_o);
		compare_busy("reset busy", '0, core_busy_o);
		@(posedge clk);
		#1;

		for (int r = 0; r < ROWS; r++) begin
			row = r;
			go_base = go_log.size();
			frame_base = frames.size();
			for (int k = 0; k < jobs_tab[r]; k++)
				make_job(sent[k]);
			for (int k = 0; k < jobs_tab[r]; k++) begin
				send_job(sent[k]);
				// the stop bit of the last byte has just ended
				if (k == 0)
					end_cyc = cycles;
				repeat (gap_tab[r]) @(posedge clk);
				#1;
			end

			while (frames.size() < frame_base + acc_tab[r])
				@(posedge clk);
			compare_count($sformatf("%s core starts", name_tab[r]), acc_tab[r],
				go_log.size() - go_base);
			// all cores are free when the first job of a row arrives
			compare_count($sformatf("%s start latency", name_tab[r]), 2,
				go_cyc[go_base] - end_cyc);
			for (int k = 0; k < acc_tab[r]; k++) begin
				test = $sformatf("%s job %0d", name_tab[r], k);
				compare_core(test, core_tab[r][k], go_log[go_base + k]);
				compare_job(test, sent[k], job_log[go_base + k]);
				compare_busy(test, busy_tab[r][k], busy_log[go_base + k]);
			end
			for (int k = 0; k < acc_tab[r]; k++) begin
				j = order_tab[r][k];
				test = $sformatf("%s frame %0d", name_tab[r], k);
				compare_result(test, model_result(sent[j], core_tab[r][j]),
					frames[frame_base + k]);
			end

			// let the cores and the result line settle for one more frame time
			while (core_busy_o != '0)
				@(posedge clk);
			repeat (RES_CYCLES + 200) @(posedge clk);
			#1;
			compare_count($sformatf("%s frames", name_tab[r]), acc_tab[r],
				frames.size() - frame_base);
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: miner.f
+incdir+rtl
rtl/miner_pkg.sv
rtl/uart_receiver.sv
rtl/uart_sender.sv
rtl/job_receive.sv
rtl/job_dispatch.sv
rtl/result_collect.sv
rtl/result_send.sv
rtl/miner.sv
testbench/tb_miner.sv

// File: run_sim.sh
#!/bin/sh
# build the miner testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_miner -f miner.f -o tb_miner > build.log 2>&1 ||
	{ cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_miner > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; } ||
	grep -q "TEST RESULT: PASS" sim.log || { echo "simulation did not finish"; exit 1; }
